// ==== Bender.yml ====
package:
  name: src_stream

export_include_dirs:
  - verilog

sources:
  - verilog/src_stream_pkg.sv
  - verilog/src_addr_gen.sv
  - verilog/src_stream_fifo.sv
  - verilog/src_load_unit.sv
  - verilog/src_stream_top.sv
  - target: test
    files:
      - verification/tb_mem_model.sv
      - verification/tb_src_stream.sv

// ==== verification/tb_mem_model.sv ====
////////////////////////////////////////
// memory responder, no storage array
// byte a reads as (xor of a's bytes) * 8'h9d + 8'h37
// in-order answers, 1 to 6 cycles late
// pending answers dropped on clear_i
////////////////////////////////////////
`timescale 1ns/1ps
`include "src_stream_config.svh"

module tb_mem_model #(
  parameter int unsigned SEED = 1
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         mem_req_valid_i,
  input  src_stream_pkg::src_mem_req_t mem_req_i,
  output logic                         mem_req_ready_o,
  output logic                         mem_rsp_valid_o,
  output src_stream_pkg::src_mem_rsp_t mem_rsp_o,
  input  logic                         mem_rsp_ready_i
);
  import src_stream_pkg::*;

  localparam int MAX_LAT = 6;

  src_addr_t pend_addr_q [$]; // granted word addresses, oldest first
  int        pend_due_q [$];  // first cycle each answer may show
  integer    seed;
  int        cyc;

  function automatic logic [7:0] byte_at(input src_addr_t a);
    logic [7:0] fold;
    logic [7:0] b;
    fold = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]; // every address bit counts
    b    = fold * 8'h9d + 8'h37;
    return b;
  endfunction

  function automatic src_mem_rsp_t word_at(input src_addr_t a);
    src_mem_rsp_t rsp;
    int           i;
    for (i = 0; i < `SRC_MEM_W / 8; i++) begin
      rsp.rdata[8*i +: 8] = byte_at(a + src_addr_t'(i)); // little endian
    end
    return rsp;
  endfunction

  initial begin : responder
    logic [31:0] rnd;
    seed            = SEED;
    cyc             = 0;
    mem_req_ready_o = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_o       = '0;
    forever begin
      @(posedge clk_i);
      cyc++;
      if (!rst_ni || clear_i) begin
        pend_addr_q.delete(); // in-flight loads are lost
        pend_due_q.delete();
      end else begin
        if (mem_rsp_valid_o && mem_rsp_ready_i) begin
          void'(pend_addr_q.pop_front());
          void'(pend_due_q.pop_front());
        end
        if (mem_req_valid_i && mem_req_ready_o) begin
          rnd = $random(seed);
          pend_addr_q.push_back({mem_req_i.addr[`SRC_ADDR_W-1:2], 2'b00}); // whole word
          pend_due_q.push_back(cyc + 1 + int'(rnd % MAX_LAT));
        end
      end
      @(negedge clk_i);
      rnd             = $random(seed);
      mem_req_ready_o = rst_ni & rnd[0]; // grant half the time
      // head stays put until taken
      if (pend_addr_q.size() != 0 && pend_due_q[0] <= cyc) begin
        mem_rsp_valid_o = 1'b1;
        mem_rsp_o       = word_at(pend_addr_q[0]);
      end else begin
        mem_rsp_valid_o = 1'b0;
      end
    end
  end

endmodule

// ==== verification/tb_src_stream.sv ====
////////////////////////////////////////
// source streamer testbench
// random 2D jobs checked beat by beat
// flags checked every cycle
////////////////////////////////////////
`timescale 1ns/1ps
`include "src_stream_config.svh"

module tb_src_stream;
  import src_stream_pkg::*;

  localparam int unsigned SEED      = 32'h6ab7_4256;
  localparam int          CLK_PER   = 40; // ns
  localparam int          RST_CYC   = 8;
  localparam int          NUM_JOBS  = 12;
  localparam int          NUM_ALGN  = 4;  // leading aligned contiguous jobs
  localparam int          CLEAR_JOB = 7;  // job cut short by clear
  localparam int          MAX_LEN   = 32;
  localparam int          WDOG_CYC  = NUM_JOBS * MAX_LEN * 20 + 500;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         clear;
  src_ctrl_t    ctrl;
  src_flags_t   flags;
  logic         mem_req_valid;
  src_mem_req_t mem_req;
  logic         mem_req_ready;
  logic         mem_rsp_valid;
  src_mem_rsp_t mem_rsp;
  logic         mem_rsp_ready;
  logic         out_valid;
  src_data_t    out_data;
  logic         out_ready;

  integer    seed;      // job stimulus
  integer    rdy_seed;  // out_ready toggling
  src_data_t exp_q [$]; // beats still owed by the running job
  logic      busy;      // job launched and no done yet
  int        beat_idx;  // beats seen in this job
  int        done_cnt;
  int        cyc_cnt;
  int        beat_errs;
  int        flag_errs;
  int        other_errs;

  src_stream_top DUT (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .clear_i         ( clear         ),
    .ctrl_i          ( ctrl          ),
    .flags_o         ( flags         ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_o       ( mem_req       ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       ),
    .mem_rsp_ready_o ( mem_rsp_ready ),
    .out_valid_o     ( out_valid     ),
    .out_data_o      ( out_data      ),
    .out_ready_i     ( out_ready     )
  );

  tb_mem_model #(.SEED(SEED + 1)) u_mem (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .clear_i         ( clear         ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_req_i       ( mem_req       ),
    .mem_req_ready_o ( mem_req_ready ),
    .mem_rsp_valid_o ( mem_rsp_valid ),
    .mem_rsp_o       ( mem_rsp       ),
    .mem_rsp_ready_i ( mem_rsp_ready )
  );

  function automatic logic [7:0] pattern_byte(input src_addr_t a);
    logic [7:0] fold;
    logic [7:0] b;
    fold = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]; // all address bytes
    b    = fold * 8'h9d + 8'h37;
    return b;
  endfunction

  function automatic src_data_t beat_value(input src_addr_t a);
    return {pattern_byte(a + 3), pattern_byte(a + 2), pattern_byte(a + 1), pattern_byte(a)};
  endfunction

  // beat k sits at row k / d0_len, column k % d0_len
  function automatic src_addr_t beat_addr(input src_ctrl_t c, input int k);
    src_addr_t col;
    src_addr_t row;
    col = src_addr_t'(k % c.d0_len);
    row = src_addr_t'(k / c.d0_len);
    return c.base_addr + col * src_addr_t'(c.d0_stride) + row * c.d1_stride;
  endfunction

  task automatic check_beat(input src_data_t exp, input src_data_t act, input int idx);
    if (act !== exp) begin
      $display("FAIL out_data_o beat %0d: expected %h, got %h", idx, exp, act);
      beat_errs++;
    end
  endtask

  task automatic check_flags(input src_flags_t exp, input src_flags_t act);
    if (act !== exp) begin
      $display("FAIL flags_o cycle %0d: expected %h, got %h", cyc_cnt, exp, act);
      flag_errs++;
    end
  endtask

  task automatic make_job(input int n, output src_ctrl_t job);
    logic [31:0] r;
    job       = '0;
    job.start = 1'b1;
    r         = $random(seed);
    job.tot_len = (n == CLEAR_JOB) ? MAX_LEN : 1 + r[4:0];
    job.d0_len  = 1 + r[10:8]; // 1 to 8 per row
    r = $random(seed);
    if (n < NUM_ALGN) begin
      job.base_addr = {16'h0, r[15:2], 2'b00};
      job.d0_stride = 16'd4; // contiguous words
      job.d1_stride = src_addr_t'(job.d0_len) * 4;
    end else begin
      job.base_addr = {r[31:2], 2'b00} + src_addr_t'(1 + r[1:0] % 3); // never aligned
      r = $random(seed);
      job.d0_stride = {r[4:0], 1'b1}; // odd, may overlap
      job.d1_stride = r[31] ? {r[30:6], 1'b1} : {24'h0, r[13:7], 1'b1};
    end
  endtask

  task automatic run_job(input src_ctrl_t job, input int n);
    int k;
    int done_before;
    while (!flags.ready_start) @(negedge clk);
    for (k = 0; k < job.tot_len; k++) exp_q.push_back(beat_value(beat_addr(job, k)));
    done_before = done_cnt;
    ctrl        = job;
    @(negedge clk);
    ctrl.start = 1'b0;
    if (n == CLEAR_JOB) begin
      while (beat_idx < 3) @(negedge clk);
      clear = 1'b1; // abort mid job
      @(negedge clk);
      clear = 1'b0;
      repeat (4) @(negedge clk);
      if (done_cnt != done_before) begin
        $display("job %0d raised done although it was cleared", n);
        other_errs++;
      end
    end else begin
      while (done_cnt == done_before) @(negedge clk);
      if (exp_q.size() != 0) begin
        $display("job %0d finished with %0d beats missing", n, exp_q.size());
        other_errs++;
      end
    end
  endtask

  initial begin : clock_gen
    forever #(CLK_PER / 2) clk = ~clk;
  end

  initial begin : ready_toggle
    rdy_seed = SEED + 2;
    forever begin
      @(negedge clk);
      out_ready = ($random(rdy_seed) & 3) != 0; // three quarters ready
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYC) @(posedge clk);
    $display("timeout: run still going after %0d cycles, a job never finished", WDOG_CYC);
    $display("TB FAILED");
    $finish;
  end

  // transfers and flags sampled on the edge that moves them
  always @(posedge clk) begin : monitor
    src_flags_t exp_flags;
    src_data_t  exp_beat;
    cyc_cnt++;
    if (rst_n) begin
      exp_flags.ready_start = !busy;
      exp_flags.done        = busy && (exp_q.size() == 0); // cycle after last beat
      check_flags(exp_flags, flags);
      if (flags.done) done_cnt++;
      if (mem_req_valid && mem_req.addr[1:0] != 2'b00) begin
        $display("memory request at %h is not word aligned", mem_req.addr);
        other_errs++;
      end
      if (out_valid && out_ready && !clear) begin
        if (!busy || exp_q.size() == 0) begin
          $display("beat %h delivered while no job expects one", out_data);
          other_errs++;
        end else begin
          exp_beat = exp_q.pop_front();
          check_beat(exp_beat, out_data, beat_idx);
          beat_idx++;
        end
      end
      if (clear) begin
        busy = 1'b0;
        exp_q.delete();
      end else if (exp_flags.done) begin
        busy = 1'b0;
      end else if (!busy && ctrl.start) begin
        busy     = 1'b1; // launch edge
        beat_idx = 0;
      end
    end
  end

  initial begin : stimulus
    src_ctrl_t job;
    int        n;
    seed       = SEED;
    rst_n      = 1'b0;
    clear      = 1'b0;
    ctrl       = '0;
    out_ready  = 1'b0;
    busy       = 1'b0;
    beat_idx   = 0;
    done_cnt   = 0;
    cyc_cnt    = 0;
    beat_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    repeat (RST_CYC) @(negedge clk);
    rst_n = 1'b1;
    for (n = 0; n < NUM_JOBS; n++) begin
      make_job(n, job);
      run_job(job, n);
    end
    repeat (20) @(negedge clk); // idle tail, no stray beats
    if (done_cnt != NUM_JOBS - 1) begin
      $display("FAIL done pulse count: expected %h, got %h", NUM_JOBS - 1, done_cnt);
      other_errs++;
    end
    $display("errors: %0d beat, %0d flag, %0d other", beat_errs, flag_errs, other_errs);
    if (beat_errs + flag_errs + other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/src_stream_pkg.sv
verilog/src_addr_gen.sv
verilog/src_stream_fifo.sv
verilog/src_load_unit.sv
verilog/src_stream_top.sv
verification/tb_mem_model.sv
verification/tb_src_stream.sv

// ==== verilog/src_addr_gen.sv ====
////////////////////////////////////////
// walks base + i*d0_stride + j*d1_stride
// d0_len must be nonzero
// addresses wrap modulo 2^SRC_ADDR_W
////////////////////////////////////////
`timescale 1ns/1ps
`include "src_stream_config.svh"

module src_addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      launch_i,
  input  src_stream_pkg::src_ctrl_t gen_cfg_i,
  output logic                      addr_valid_o,
  output src_stream_pkg::src_addr_t addr_o,
  input  logic                      addr_ready_i,
  output logic                      gen_done_o
);
  import src_stream_pkg::*;

  src_ctrl_t             cfg_q;      // job copy
  src_addr_t             addr_q;     // current address
  src_addr_t             row_q;      // start of current row
  logic [`SRC_CNT_W-1:0] d0_cnt_q;   // inner index
  logic [`SRC_CNT_W-1:0] beat_cnt_q; // addresses handed out
  logic [`SRC_CNT_W-1:0] beat_nxt;
  logic                  active_q;
  logic                  done_q;
  logic                  addr_fire;
  logic                  row_end;

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q;
  assign gen_done_o   = done_q;
  assign addr_fire    = active_q & addr_ready_i;
  assign beat_nxt     = beat_cnt_q + 1'b1;
  assign row_end      = (d0_cnt_q == cfg_q.d0_len - 1'b1); // last beat of the row

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      d0_cnt_q   <= '0;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      d0_cnt_q   <= '0;
      beat_cnt_q <= '0;
    end else if (launch_i) begin
      active_q   <= (gen_cfg_i.tot_len != '0); // empty job finishes at once
      done_q     <= (gen_cfg_i.tot_len == '0);
      d0_cnt_q   <= '0;
      beat_cnt_q <= '0;
    end else if (addr_fire) begin
      beat_cnt_q <= beat_nxt;
      d0_cnt_q   <= row_end ? '0 : d0_cnt_q + 1'b1;
      if (beat_nxt == cfg_q.tot_len) begin
        active_q <= 1'b0;
        done_q   <= 1'b1; // held until next launch
      end
    end
  end

  // address datapath
  always_ff @(posedge clk_i) begin
    if (launch_i) begin
      cfg_q  <= gen_cfg_i;
      addr_q <= gen_cfg_i.base_addr;
      row_q  <= gen_cfg_i.base_addr;
    end else if (addr_fire) begin
      if (row_end) begin
        row_q  <= row_q + cfg_q.d1_stride;
        addr_q <= row_q + cfg_q.d1_stride; // next row restarts from its base
      end else begin
        addr_q <= addr_q + src_addr_t'(cfg_q.d0_stride);
      end
    end
  end

  // load unit may only relaunch once the previous pattern is exhausted
  a_no_launch_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    launch_i |-> !active_q)
    else $error("launch while addresses pending");

endmodule

// ==== verilog/src_load_unit.sv ====
////////////////////////////////////////
// job FSM, load issue and realignment
// memory must answer in request order
// rsp to output path is combinational
////////////////////////////////////////
`timescale 1ns/1ps
`include "src_stream_config.svh"

module src_load_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  src_stream_pkg::src_ctrl_t    ctrl_i,
  output src_stream_pkg::src_flags_t   flags_o,
  output logic                         launch_o,
  output src_stream_pkg::src_ctrl_t    gen_cfg_o,
  input  logic                         gen_done_i,
  input  logic                         addr_valid_i,
  input  src_stream_pkg::src_addr_t    addr_i,
  output logic                         addr_ready_o,
  output logic                         mem_req_valid_o,
  output src_stream_pkg::src_mem_req_t mem_req_o,
  input  logic                         mem_req_ready_i,
  input  logic                         mem_rsp_valid_i,
  input  src_stream_pkg::src_mem_rsp_t mem_rsp_i,
  output logic                         mem_rsp_ready_o,
  output logic                         offs_push_valid_o,
  output src_stream_pkg::src_offs_t    offs_push_o,
  input  logic                         offs_push_ready_i,
  input  logic                         offs_pop_valid_i,
  input  src_stream_pkg::src_offs_t    offs_pop_i,
  output logic                         offs_pop_ready_o,
  output logic                         out_valid_o,
  output src_stream_pkg::src_data_t    out_data_o,
  input  logic                         out_ready_i
);
  import src_stream_pkg::*;

  src_state_e            cs_q;
  src_state_e            ns;
  logic [`SRC_CNT_W-1:0] beat_cnt_q; // beats delivered this job
  logic [`SRC_CNT_W-1:0] tot_len_q;
  logic                  req_fire;
  logic                  out_fire;
  logic                  last_beat;

  assign launch_o  = (cs_q == SRC_IDLE) & ctrl_i.start;
  assign gen_cfg_o = ctrl_i; // generator samples it on launch
  assign last_beat = (beat_cnt_q == tot_len_q);

  always_comb begin : fsm_comb
    ns                  = cs_q;
    flags_o.ready_start = 1'b0;
    flags_o.done        = 1'b0;
    case (cs_q)
      SRC_IDLE: begin
        flags_o.ready_start = 1'b1;
        if (ctrl_i.start) ns = SRC_WORKING;
      end
      SRC_WORKING: begin
        if (gen_done_i) ns = SRC_DRAIN; // all addresses queued
      end
      SRC_DRAIN: begin
        if (last_beat) begin
          ns           = SRC_IDLE;
          flags_o.done = 1'b1; // single-cycle pulse
        end
      end
      default: ns = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_seq
    if (!rst_ni) cs_q <= SRC_IDLE;
    else if (clear_i) cs_q <= SRC_IDLE;
    else cs_q <= ns;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) beat_cnt_q <= '0;
    else if (clear_i || launch_o) beat_cnt_q <= '0;
    else if (out_fire) beat_cnt_q <= beat_cnt_q + 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (launch_o) tot_len_q <= ctrl_i.tot_len;
  end

  // request side, held back once the offset FIFO is full
  assign mem_req_valid_o   = (cs_q != SRC_IDLE) & addr_valid_i & offs_push_ready_i;
  assign mem_req_o.addr    = {addr_i[`SRC_ADDR_W-1:2], 2'b00}; // word aligned
  assign req_fire          = mem_req_valid_o & mem_req_ready_i;
  assign addr_ready_o      = req_fire; // pop address on grant
  assign offs_push_valid_o = req_fire;
  assign offs_push_o       = addr_i[1:0];

  // response side
  assign out_valid_o      = mem_rsp_valid_i;
  assign mem_rsp_ready_o  = out_ready_i;
  assign out_fire         = out_valid_o & out_ready_i;
  assign offs_pop_ready_o = out_fire;

  // pick bytes offs..offs+3 out of the wide word
  always_comb begin : realign
    case (offs_pop_i)
      2'd0:    out_data_o = mem_rsp_i.rdata[0 +: `SRC_DATA_W];
      2'd1:    out_data_o = mem_rsp_i.rdata[8 +: `SRC_DATA_W];
      2'd2:    out_data_o = mem_rsp_i.rdata[16 +: `SRC_DATA_W];
      default: out_data_o = mem_rsp_i.rdata[24 +: `SRC_DATA_W];
    endcase
  end

  // memory hold and offset FIFO head together keep the beat steady
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("output beat changed under stall");

  // every response needs the offset of its granted request
  a_rsp_has_offs: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_rsp_valid_i |-> offs_pop_valid_i)
    else $error("response without pending offset");

endmodule

// ==== verilog/src_stream_config.svh ====
////////////////////////////////////////
// widths and depths of the source streamer
// SRC_MEM_W must stay SRC_DATA_W + 32
// offs depth caps the loads in flight
////////////////////////////////////////
`ifndef SRC_STREAM_CONFIG_SVH
`define SRC_STREAM_CONFIG_SVH

`define SRC_DATA_W 32 // output beat

`define SRC_MEM_W (`SRC_DATA_W + 32) // spare word for misaligned loads

`define SRC_ADDR_W 32 // byte address

`define SRC_CNT_W 16 // length and beat counters

`define SRC_ADDR_FIFO_DEPTH 2 // generator to load unit

`define SRC_OFFS_FIFO_DEPTH 8 // max outstanding loads

`endif

// ==== verilog/src_stream_fifo.sv ====
////////////////////////////////////////
// synchronous FIFO, any payload type
// pop data is read from storage registers
// one cycle from push to pop side
////////////////////////////////////////
`timescale 1ns/1ps

module src_stream_fifo #(
  parameter type         T     = logic [31:0],
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH]; // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q; // occupancy
  logic             push_fire;
  logic             pop_fire;

  // pointer step that wraps at any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (cnt_q != CNT_W'(DEPTH)); // low when full
  assign pop_valid_o  = (cnt_q != '0);            // low when empty
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_fire    = push_valid_i & push_ready_o;
  assign pop_fire     = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_fire) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push_fire && !pop_fire) cnt_q <= cnt_q + 1'b1;
      else if (pop_fire && !push_fire) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) mem_q[wr_ptr_q] <= push_data_i;
  end

  // a push never lands on the unread head entry
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    push_fire && (cnt_q != '0) |-> wr_ptr_q != rd_ptr_q)
    else $error("push accepted while full");

  // a pop request always finds an entry
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    pop_ready_i |-> pop_valid_o)
    else $error("pop while empty");

endmodule

// ==== verilog/src_stream_pkg.sv ====
////////////////////////////////////////
// types of the source streamer
// strides and lengths are unsigned
// d0_len and tot_len count beats
////////////////////////////////////////
`include "src_stream_config.svh"

package src_stream_pkg;

  typedef logic [`SRC_ADDR_W-1:0] src_addr_t; // byte address
  typedef logic [1:0]             src_offs_t; // byte within a 32-bit word
  typedef logic [`SRC_DATA_W-1:0] src_data_t; // one stream beat

  // job configuration, sampled at launch
  typedef struct packed {
    logic                  start;     // job request
    src_addr_t             base_addr; // first byte address
    logic [`SRC_CNT_W-1:0] d0_len;    // beats per inner row
    logic [15:0]           d0_stride; // inner step in bytes
    src_addr_t             d1_stride; // outer step in bytes
    logic [`SRC_CNT_W-1:0] tot_len;   // beats in the job
  } src_ctrl_t;

  typedef struct packed {
    logic ready_start; // idle, job may start
    logic done;        // one cycle at job end
  } src_flags_t;

  typedef struct packed {
    src_addr_t addr; // always word aligned
  } src_mem_req_t;

  typedef struct packed {
    logic [`SRC_MEM_W-1:0] rdata; // two words from the aligned address
  } src_mem_rsp_t;

  typedef enum logic [1:0] {
    SRC_IDLE    = 2'd0, // waiting for start
    SRC_WORKING = 2'd1, // generator still emitting
    SRC_DRAIN   = 2'd2  // waiting for the last beats
  } src_state_e;

endpackage

// ==== verilog/src_stream_top.sv ====
////////////////////////////////////////
// source streamer top, wiring only
// memory answers in order, any latency
// loads in flight capped by offs depth
////////////////////////////////////////
`timescale 1ns/1ps
`include "src_stream_config.svh"

module src_stream_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  src_stream_pkg::src_ctrl_t    ctrl_i,
  output src_stream_pkg::src_flags_t   flags_o,
  output logic                         mem_req_valid_o,
  output src_stream_pkg::src_mem_req_t mem_req_o,
  input  logic                         mem_req_ready_i,
  input  logic                         mem_rsp_valid_i,
  input  src_stream_pkg::src_mem_rsp_t mem_rsp_i,
  output logic                         mem_rsp_ready_o,
  output logic                         out_valid_o,
  output src_stream_pkg::src_data_t    out_data_o,
  input  logic                         out_ready_i
);
  import src_stream_pkg::*;

  logic      launch;
  src_ctrl_t gen_cfg;
  logic      gen_done;
  logic      gen_addr_valid;  // generator to address FIFO
  src_addr_t gen_addr;
  logic      gen_addr_ready;
  logic      fifo_addr_valid; // address FIFO to load unit
  src_addr_t fifo_addr;
  logic      fifo_addr_ready;
  logic      offs_push_valid; // offsets of granted loads
  src_offs_t offs_push;
  logic      offs_push_ready;
  logic      offs_pop_valid;
  src_offs_t offs_pop;
  logic      offs_pop_ready;

  src_addr_gen i_addr_gen (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .launch_i     ( launch         ),
    .gen_cfg_i    ( gen_cfg        ),
    .addr_valid_o ( gen_addr_valid ),
    .addr_o       ( gen_addr       ),
    .addr_ready_i ( gen_addr_ready ),
    .gen_done_o   ( gen_done       )
  );

  src_stream_fifo #(
    .T     ( src_addr_t           ),
    .DEPTH ( `SRC_ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( gen_addr_valid  ),
    .push_data_i  ( gen_addr        ),
    .push_ready_o ( gen_addr_ready  ),
    .pop_valid_o  ( fifo_addr_valid ),
    .pop_data_o   ( fifo_addr       ),
    .pop_ready_i  ( fifo_addr_ready )
  );

  src_stream_fifo #(
    .T     ( src_offs_t           ),
    .DEPTH ( `SRC_OFFS_FIFO_DEPTH )
  ) i_offs_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( offs_push_valid ),
    .push_data_i  ( offs_push       ),
    .push_ready_o ( offs_push_ready ),
    .pop_valid_o  ( offs_pop_valid  ),
    .pop_data_o   ( offs_pop        ),
    .pop_ready_i  ( offs_pop_ready  )
  );

  src_load_unit i_load_unit (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .ctrl_i            ( ctrl_i          ),
    .flags_o           ( flags_o         ),
    .launch_o          ( launch          ),
    .gen_cfg_o         ( gen_cfg         ),
    .gen_done_i        ( gen_done        ),
    .addr_valid_i      ( fifo_addr_valid ),
    .addr_i            ( fifo_addr       ),
    .addr_ready_o      ( fifo_addr_ready ),
    .mem_req_valid_o   ( mem_req_valid_o ),
    .mem_req_o         ( mem_req_o       ),
    .mem_req_ready_i   ( mem_req_ready_i ),
    .mem_rsp_valid_i   ( mem_rsp_valid_i ),
    .mem_rsp_i         ( mem_rsp_i       ),
    .mem_rsp_ready_o   ( mem_rsp_ready_o ),
    .offs_push_valid_o ( offs_push_valid ),
    .offs_push_o       ( offs_push       ),
    .offs_push_ready_i ( offs_push_ready ),
    .offs_pop_valid_i  ( offs_pop_valid  ),
    .offs_pop_i        ( offs_pop        ),
    .offs_pop_ready_o  ( offs_pop_ready  ),
    .out_valid_o       ( out_valid_o     ),
    .out_data_o        ( out_data_o      ),
    .out_ready_i       ( out_ready_i     )
  );

endmodule
